// File: audio_sys.f
+incdir+design
design/audio_pkg.sv
design/sine_table_arbiter.sv
design/tone_generator.sv
design/i2s_receiver.sv
design/pdm_modulator.sv
design/audio_top.sv
testbench/audio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module audio_top_tb -f audio_sys.f &&
  ./obj_dir/Vaudio_top_tb | tee /dev/stderr | grep -q "Simulation completed successfully" &&
  echo "run_sim: PASS" ||
  { echo "run_sim: FAIL"; exit 1; }

// File: testbench/audio_top_tb.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module audio_top_tb
  import audio_pkg::*;
();

  localparam int  TICK_CYCLES = 1 << `AUDIO_TICK_BITS;
  localparam int  TONE_WAIT   = TICK_CYCLES + 64;             // one tick period plus slack
  localparam int  MIC_WAIT    = 8 * `I2S_SLOTS * `I2S_DIV;    // two full i2s frames
  localparam int  DENS_CYCLES = 256;
  localparam real PI          = 3.14159265358979;

  logic        audio_clk = 1'b0;
  logic        arst_n;
  logic        tone_sel;
  logic [1:0]  spk_en;
  logic        mic_data;
  logic        mic_bclk;
  logic        mic_lrcl;
  mic_sample_t mic_sample;
  tone_amp_t   tone_amp;
  logic        tone_valid;
  logic        spk_l;
  logic        spk_r;

  int          errors = 0;
  int          checks = 0;
  int          cyc    = 0;  // cycles since reset release
  int          seed   = 96;
  logic [`MIC_BITS-1:0] mic_word; // word sent in the current frame

  always #20 audio_clk = ~audio_clk; // 40 ns period

  audio_top uut (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .tone_sel   (tone_sel),
    .spk_en     (spk_en),
    .mic_data   (mic_data),
    .mic_bclk   (mic_bclk),
    .mic_lrcl   (mic_lrcl),
    .mic_sample (mic_sample),
    .tone_amp   (tone_amp),
    .tone_valid (tone_valid),
    .spk_l      (spk_l),
    .spk_r      (spk_r)
  );

  // counts edges after release, ticks fall on multiples of 4096
  initial begin : cycle_count
    forever begin
      @(posedge audio_clk);
      if (arst_n) cyc++;
    end
  end

  // i2s microphone, data changes after the falling bclk edge
  initial begin : mic_model
    logic bclk_prev;
    logic lrcl_prev;
    int   slot;
    mic_data  = 1'b0;
    bclk_prev = 1'b0;
    lrcl_prev = 1'b0;
    slot      = 0;       // reset starts in slot 0 of a left half
    mic_word  = `MIC_BITS'($random(seed));
    forever begin
      @(posedge audio_clk);
      #5;
      if (bclk_prev && !mic_bclk) begin
        if (lrcl_prev && !mic_lrcl) begin
          slot     = 0;  // new frame
          mic_word = `MIC_BITS'($random(seed));
        end else begin
          slot++;
        end
      end
      bclk_prev = mic_bclk;
      lrcl_prev = mic_lrcl;
      // msb in slot 1, one delay slot after lrcl falls
      if (!mic_lrcl && slot >= 1 && slot <= `MIC_BITS) mic_data = mic_word[`MIC_BITS - slot];
      else mic_data = 1'b0;
    end
  end

  // expected tone: phase after n ticks, quarter table by formula, full-wave fold
  function automatic tone_amp_t tone_model(logic [`PHASE_BITS-1:0] incr, int ticks);
    logic [`PHASE_BITS-1:0] phase;
    logic [1:0]             quad;
    int                     off;
    int                     mag;
    phase = incr * `PHASE_BITS'(ticks); // wraps like the accumulator
    quad  = phase[`PHASE_BITS-1 -: 2];
    off   = int'(phase[`PHASE_BITS-3 -: 8]);
    if (quad[0]) off = 255 - off;       // mirrored quadrants
    mag = int'($floor(127.0 * $sin((real'(off) + 0.5) * PI / 512.0) + 0.5));
    if (quad[1]) mag = -mag;            // lower half negative
    return tone_amp_t'(mag);
  endfunction

  task automatic check_amp(string name, tone_amp_t exp, tone_amp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_mic(string name, mic_sample_t exp, mic_sample_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected valid=%0b data=%h, actual valid=%0b data=%h",
               name, exp.valid, exp.data, act.valid, act.data);
    end
  endtask

  task automatic check_count(string name, int exp, int act, int tol);
    checks++;
    if (act < exp - tol || act > exp + tol) begin
      errors++;
      $display("FAILED %s: expected %0d (+-%0d), actual %0d", name, exp, tol, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic wait_tone_valid(string name, output bit ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    while (!ok && waited < TONE_WAIT) begin
      @(posedge audio_clk);
      #5;
      waited++;
      ok = (tone_valid === 1'b1);
    end
    if (!ok) begin
      errors++;
      $display("%s: no tone_valid pulse within %0d cycles", name, TONE_WAIT);
    end
  endtask

  task automatic wait_mic_valid(string name, output bit ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    while (!ok && waited < MIC_WAIT) begin
      @(posedge audio_clk);
      #5;
      waited++;
      ok = (mic_sample.valid === 1'b1);
    end
    if (!ok) begin
      errors++;
      $display("%s: no microphone sample within %0d cycles", name, MIC_WAIT);
    end
  endtask

  task automatic check_idle(string when);
    check_bit({when, " spk_l"}, 1'b0, spk_l);
    check_bit({when, " spk_r"}, 1'b0, spk_r);
    check_bit({when, " tone_valid"}, 1'b0, tone_valid);
    check_bit({when, " mic valid"}, 1'b0, mic_sample.valid);
    check_bit({when, " mic_bclk"}, 1'b0, mic_bclk);
    check_bit({when, " mic_lrcl"}, 1'b0, mic_lrcl);
  endtask

  task automatic run_reset_test();
    for (int i = 0; i < 4; i++) begin
      @(posedge audio_clk);
      #5;
      check_idle($sformatf("reset cycle %0d", i));
    end
    arst_n = 1'b1;  // release after 4 cycles
    @(posedge audio_clk);
    #5;
    check_idle("after release");
  endtask

  task automatic run_tone_test(string name, logic sel, logic [`PHASE_BITS-1:0] incr);
    bit        ok;
    tone_amp_t exp;
    tone_sel = sel;
    for (int n = 0; n < 8; n++) begin
      wait_tone_valid(name, ok);
      if (ok) begin
        exp = tone_model(incr, cyc / TICK_CYCLES); // both phases run on every tick
        check_amp($sformatf("%s tick %0d", name, cyc / TICK_CYCLES), exp, tone_amp);
      end
    end
  endtask

  task automatic run_mic_test();
    bit          ok;
    mic_sample_t exp;
    for (int f = 0; f < 3; f++) begin
      wait_mic_valid($sformatf("mic frame %0d", f), ok);
      if (ok) begin
        exp.valid = 1'b1;
        exp.data  = mic_word[`MIC_BITS-1 -: `MIC_OUT_BITS]; // top 16 of 18
        check_mic($sformatf("mic frame %0d", f), exp, mic_sample);
      end
    end
  endtask

  task automatic count_ones(output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    for (int i = 0; i < DENS_CYCLES; i++) begin
      @(posedge audio_clk);
      #5;
      if (spk_l === 1'b1) ones_l++;
      if (spk_r === 1'b1) ones_r++;
    end
  endtask

  task automatic run_speaker_test();
    bit                     ok;
    logic [`PHASE_BITS-1:0] incr;
    tone_amp_t              amp_exp;
    int                     level;
    int                     exp;
    int                     ones_l;
    int                     ones_r;
    wait_tone_valid("speaker", ok);
    if (ok) begin
      incr    = tone_sel ? `TONE_A_INCR : `TONE_B_INCR;
      amp_exp = tone_model(incr, cyc / TICK_CYCLES);  // tone now on the modulator
      level   = int'(amp_exp) * 256;                  // widened tone
      exp     = (level + 32768) * DENS_CYCLES / 65536; // density rule
      spk_en = 2'b01;
      count_ones(ones_l, ones_r);
      check_count("speaker left density", exp, ones_l, 1);
      check_count("speaker right gated", 0, ones_r, 0);
      spk_en = 2'b10;                                // mirrored
      count_ones(ones_l, ones_r);
      check_count("speaker right density", exp, ones_r, 1);
      check_count("speaker left gated", 0, ones_l, 0);
      spk_en = 2'b00;
    end
  endtask

  initial begin : main
    arst_n   = 1'b0;
    tone_sel = 1'b1;
    spk_en   = 2'b00;
    run_reset_test();
    run_tone_test("tone a", 1'b1, `TONE_A_INCR);
    run_tone_test("tone b", 1'b0, `TONE_B_INCR);
    run_mic_test();
    run_speaker_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: design/audio_top.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module audio_top
  import audio_pkg::*;
(
  input  logic        audio_clk,
  input  logic        arst_n,
  input  logic        tone_sel,   // high picks tone a
  input  logic [1:0]  spk_en,     // [0] left, [1] right
  input  logic        mic_data,
  output logic        mic_bclk,
  output logic        mic_lrcl,
  output mic_sample_t mic_sample,
  output tone_amp_t   tone_amp,
  output logic        tone_valid,
  output logic        spk_l,
  output logic        spk_r
);

  logic [`AUDIO_TICK_BITS-1:0] tick_cnt;
  logic                        tick_armed; // set after the first full wrap
  logic                        sample_tick;
  table_req_t                  req_a;
  table_req_t                  req_b;
  logic                        grant_a;
  logic                        grant_b;
  logic [`TABLE_MAG_BITS-1:0]  table_data; // shared by both generators
  tone_amp_t                   amp_a;
  tone_amp_t                   amp_b;
  logic                        valid_a;
  logic                        valid_b;
  pdm_level_t                  pdm_level;
  logic                        pdm_bit;

  // free-running tick counter
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt   <= '0;
      tick_armed <= 1'b0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      if (&tick_cnt) begin
        tick_armed <= 1'b1;
      end
    end
  end

  assign sample_tick = tick_armed & (tick_cnt == '0); // first one 4096 after reset

  sine_table_arbiter u_arbiter (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .req_a      (req_a),
    .req_b      (req_b),
    .grant_a    (grant_a),
    .grant_b    (grant_b),
    .table_data (table_data)
  );

  tone_generator #(.PHASE_INCR(`TONE_A_INCR)) u_tone_a (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .step       (sample_tick),
    .req        (req_a),
    .grant      (grant_a),
    .table_data (table_data),
    .amp        (amp_a),
    .amp_valid  (valid_a)
  );

  tone_generator #(.PHASE_INCR(`TONE_B_INCR)) u_tone_b (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .step       (sample_tick),
    .req        (req_b),
    .grant      (grant_b),
    .table_data (table_data),
    .amp        (amp_b),
    .amp_valid  (valid_b)
  );

  assign tone_amp   = tone_sel ? amp_a : amp_b;
  assign tone_valid = tone_sel ? valid_a : valid_b;

  // sign extend, then scale to the top byte
  assign pdm_level = pdm_level_t'(tone_amp) <<< 8;

  pdm_modulator u_pdm (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .level     (pdm_level),
    .pdm       (pdm_bit)
  );

  assign spk_l = spk_en[0] & pdm_bit;
  assign spk_r = spk_en[1] & pdm_bit;

  i2s_receiver u_mic (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .mic_data  (mic_data),
    .mic_bclk  (mic_bclk),
    .mic_lrcl  (mic_lrcl),
    .sample    (mic_sample)
  );

endmodule

// File: design/pdm_modulator.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module pdm_modulator
  import audio_pkg::*;
(
  input  logic       audio_clk,
  input  logic       arst_n,
  input  pdm_level_t level,
  output logic       pdm
);

  logic [`PDM_BITS-1:0] level_u; // offset binary, 0 = full negative
  logic [`PDM_BITS-1:0] acc;
  logic [`PDM_BITS:0]   acc_sum; // carry in the top bit

  // flip the sign bit, same as adding 32768
  assign level_u = {~level[`PDM_BITS-1], level[`PDM_BITS-2:0]};

  assign acc_sum = {1'b0, acc} + {1'b0, level_u};

  // carry out is the density bit
  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
      pdm <= 1'b0;
    end else begin
      acc <= acc_sum[`PDM_BITS-1:0];
      pdm <= acc_sum[`PDM_BITS];
    end
  end

endmodule

// File: design/i2s_receiver.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module i2s_receiver
  import audio_pkg::*;
(
  input  logic        audio_clk,
  input  logic        arst_n,
  input  logic        mic_data,
  output logic        mic_bclk,
  output logic        mic_lrcl,
  output mic_sample_t sample
);

  localparam int DIV_W = $clog2(`I2S_DIV);
  localparam int BIT_W = $clog2(`I2S_SLOTS);

  logic [DIV_W-1:0]      div_cnt;
  logic                  div_end;
  logic                  bclk_rise;
  logic                  bclk_fall;
  logic [BIT_W-1:0]      bit_cnt;   // slot within the current lrcl half
  logic                  capture;
  logic                  last_bit;
  logic [`MIC_BITS-1:0]  shift;
  logic [`MIC_BITS-1:0]  shift_next;
  logic                  valid_q;
  logic [`MIC_OUT_BITS-1:0] data_q;

  assign div_end   = (div_cnt == DIV_W'(`I2S_DIV - 1));
  assign bclk_rise = div_end & ~mic_bclk;
  assign bclk_fall = div_end & mic_bclk;

  // left word sits in slots 1..18, slot 0 is the i2s delay bit
  assign capture  = bclk_rise & ~mic_lrcl & (bit_cnt != '0) &
                    (bit_cnt <= BIT_W'(`MIC_BITS));
  assign last_bit = capture & (bit_cnt == BIT_W'(`MIC_BITS));

  assign shift_next = {shift[`MIC_BITS-2:0], mic_data}; // msb first

  assign sample = '{valid: valid_q, data: data_q};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt  <= '0;
      mic_bclk <= 1'b0;
      mic_lrcl <= 1'b0;
      bit_cnt  <= '0;
      valid_q  <= 1'b0;
    end else begin
      div_cnt <= div_end ? '0 : div_cnt + 1'b1;
      if (div_end) begin
        mic_bclk <= ~mic_bclk;
      end
      // slot and word clock move on the falling edge
      if (bclk_fall) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == BIT_W'(`I2S_SLOTS - 1)) begin
          mic_lrcl <= ~mic_lrcl;
        end
      end
      valid_q <= last_bit; // cycle after bit 18 is taken
    end
  end

  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift <= shift_next;
    end
    if (last_bit) begin
      data_q <= shift_next[`MIC_BITS-1 -: `MIC_OUT_BITS]; // drop 2 lsbs
    end
  end

  a_valid_pulse: assert property (@(posedge audio_clk) disable iff (!arst_n)
    sample.valid |=> !sample.valid);

endmodule

// File: design/tone_generator.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module tone_generator
  import audio_pkg::*;
#(
  parameter logic [`PHASE_BITS-1:0] PHASE_INCR = `TONE_A_INCR
) (
  input  logic                       audio_clk,
  input  logic                       arst_n,
  input  logic                       step,
  output table_req_t                 req,
  input  logic                       grant,
  input  logic [`TABLE_MAG_BITS-1:0] table_data,
  output tone_amp_t                  amp,
  output logic                       amp_valid
);

  logic [`PHASE_BITS-1:0]      phase;
  logic [`PHASE_BITS-1:0]      phase_next;
  phase_index_u                idx;       // top bits of the new phase
  logic                        req_q;
  logic [`SINE_TABLE_BITS-1:0] offset_q;
  logic [1:0]                  quad_q;    // kept until the data is back
  logic                        data_wait; // table data arrives this cycle
  logic                        pending;
  tone_amp_t                   mag;

  assign phase_next = phase + PHASE_INCR;
  assign idx.raw    = phase_next[`PHASE_BITS-1 -: `SINE_TABLE_BITS+2];

  assign req     = '{req: req_q, offset: offset_q};
  assign pending = req_q | data_wait;
  assign mag     = tone_amp_t'({1'b0, table_data}); // 0..127

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= '0;
      req_q     <= 1'b0;
      data_wait <= 1'b0;
      amp_valid <= 1'b0;
      amp       <= '0;
    end else begin
      if (step) begin
        phase <= phase_next;
        req_q <= 1'b1;       // request seen the cycle after the tick
      end else if (grant) begin
        req_q <= 1'b0;       // drop for at least one cycle
      end
      data_wait <= grant;
      amp_valid <= data_wait; // two cycles after the grant
      if (data_wait) begin
        amp <= quad_q[1] ? -mag : mag; // lower half of the wave is negative
      end
    end
  end

  // offset mirrored in quadrants 1 and 3
  always_ff @(posedge audio_clk) begin
    if (step) begin
      offset_q <= idx.fields.quadrant[0] ? ~idx.fields.offset : idx.fields.offset;
      quad_q   <= idx.fields.quadrant;
    end
  end

  // tick period must cover the arbitration latency
  a_no_step_while_busy: assert property (@(posedge audio_clk) disable iff (!arst_n)
    step |-> !pending);

endmodule

// File: design/sine_table_arbiter.sv
`timescale 1ns/100ps
`include "audio_consts.svh"

module sine_table_arbiter
  import audio_pkg::*;
(
  input  logic                       audio_clk,
  input  logic                       arst_n,
  input  table_req_t                 req_a,
  input  table_req_t                 req_b,
  output logic                       grant_a,
  output logic                       grant_b,
  output logic [`TABLE_MAG_BITS-1:0] table_data
);

  localparam int ENTRIES  = 1 << `SINE_TABLE_BITS;
  localparam int MAG_BITS = `TABLE_MAG_BITS;
  localparam int ROM_BITS = ENTRIES * MAG_BITS;

  // quarter wave sampled at bin centres, rounded to nearest
  function automatic logic [ROM_BITS-1:0] build_rom();
    logic [ROM_BITS-1:0] rom;
    real                 ang;
    real                 val;
    rom = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      ang = (real'(i) + 0.5) * 3.14159265358979 / (2.0 * ENTRIES);
      val = real'((1 << MAG_BITS) - 1) * $sin(ang);
      rom[i*MAG_BITS +: MAG_BITS] = MAG_BITS'($rtoi(val + 0.5)); // all positive
    end
    return rom;
  endfunction

  localparam logic [ROM_BITS-1:0] SINE_ROM = build_rom();

  logic                        prio_b;     // 1: b wins a tie
  logic [`SINE_TABLE_BITS-1:0] sel_offset;

  // one grant per cycle, tie goes to whoever did not win last
  assign grant_a = req_a.req & (~req_b.req | ~prio_b);
  assign grant_b = req_b.req & (~req_a.req | prio_b);

  assign sel_offset = grant_b ? req_b.offset : req_a.offset;

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      prio_b <= 1'b0; // a goes first after reset
    end else if (grant_a) begin
      prio_b <= 1'b1;
    end else if (grant_b) begin
      prio_b <= 1'b0;
    end
  end

  // table read, data lands the cycle after the grant
  always_ff @(posedge audio_clk) begin
    if (grant_a | grant_b) begin
      table_data <= SINE_ROM[sel_offset*MAG_BITS +: MAG_BITS];
    end
  end

  a_single_grant: assert property (@(posedge audio_clk) disable iff (!arst_n)
    !(grant_a && grant_b));

  // a request that lost the tie is served on the very next cycle
  a_loser_next_a: assert property (@(posedge audio_clk) disable iff (!arst_n)
    (req_a.req && !grant_a) |=> grant_a);

  a_loser_next_b: assert property (@(posedge audio_clk) disable iff (!arst_n)
    (req_b.req && !grant_b) |=> grant_b);

endmodule

// File: design/audio_pkg.sv
`include "audio_consts.svh"

package audio_pkg;

  // tone sample out of a generator
  typedef logic signed [`TONE_BITS-1:0] tone_amp_t;

  // level fed to the density modulator
  typedef logic signed [`PDM_BITS-1:0] pdm_level_t;

  // top bits of the phase split for the quarter-wave lookup
  typedef struct packed {
    logic [1:0]                  quadrant; // 0,1 positive; 1,3 mirrored
    logic [`SINE_TABLE_BITS-1:0] offset;
  } phase_fields_t;

  // same word, read raw or as quadrant/offset
  typedef union packed {
    logic [`SINE_TABLE_BITS+1:0] raw;
    phase_fields_t               fields;
  } phase_index_u;

  // one generator's read request into the shared table
  typedef struct packed {
    logic                        req;
    logic [`SINE_TABLE_BITS-1:0] offset;
  } table_req_t;

  // published microphone word
  typedef struct packed {
    logic                            valid; // one-cycle pulse
    logic signed [`MIC_OUT_BITS-1:0] data;
  } mic_sample_t;

endpackage

// File: design/audio_consts.svh
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// quarter-wave table: 256 entries, so quadrant + offset is 10 bits
`define SINE_TABLE_BITS 8
`define TABLE_MAG_BITS  7   // unsigned magnitude, peak 127

// sample tick, one per 4096 audio_clk cycles (~24 kHz at 98.3 MHz)
`define AUDIO_TICK_BITS 12

`define PHASE_BITS 32   // phase accumulator width
`define TONE_BITS  8    // signed tone amplitude
`define PDM_BITS   16   // signed modulator level

// i2s timing
`define I2S_DIV   32    // audio_clk cycles per bclk half period
`define I2S_SLOTS 32    // bclk periods per lrcl half

`define MIC_BITS     18 // bits shifted in per left word
`define MIC_OUT_BITS 16 // bits kept, msb side

// phase increments at the 24 kHz tick rate
`define TONE_A_INCR 32'h0800_0000 // 750 Hz
`define TONE_B_INCR 32'h0962_FC96

`endif
